// File: uart_link.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/link_pkg.sv
rtl/baud_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/echo_queue.sv
rtl/burst_source.sv
rtl/tx_arbiter.sv
rtl/uart_link.sv
test/tb_uart_link.sv

// File: test/tb_uart_link.sv
/* Directed testbench for the UART link
   Serial driver on rx, frame decoder on tx, echo and burst sharing checks */

`timescale 1ns/1ns
`default_nettype none

`include "uart_cfg.svh"

module tb_uart_link import uart_pkg::*; ();

  localparam int    CPB          = `UART_CLKS_PER_BIT;
  localparam int    HALF_BIT     = CPB / 2;
  localparam int    FRAME_CYC    = 10 * CPB;
  localparam int    WAIT_LIMIT   = 40 * FRAME_CYC;
  localparam int    ECHO_BYTES   = `UART_ECHO_DEPTH + 2;
  localparam byte_t BURST        = `UART_BURST_CHAR;
  // Rough frame budget over all tests, tripled for margin
  localparam int    TOTAL_FRAMES = 60;
  localparam int    WATCHDOG_NS  = TOTAL_FRAMES * FRAME_CYC * 8 * 3;

  logic   clk;
  logic   rstn;
  logic   rx;
  logic   dtr;
  logic   tx;
  byte_t  rx_data;
  logic   rx_valid;
  logic   frame_err;
  integer seed;
  // Bytes decoded on tx and bytes reported by the receiver
  byte_t  tx_q[$];
  byte_t  rxv_q[$];
  int     err_count;

  uart_link i_uart_link (
    .clk       (clk),
    .rstn      (rstn),
    .rx        (rx),
    .dtr       (dtr),
    .tx        (tx),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .frame_err (frame_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("Simulation FAILED");
    $fatal(1);
  end

  //--------------------------------------------------------------------
  // Checkers
  //--------------------------------------------------------------------

  task automatic abort_run(input string what);
    $display("%0t ns: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected 0x%h actual 0x%h", $time, name, exp, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, exp, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  //--------------------------------------------------------------------
  // Serial side
  //--------------------------------------------------------------------

  // 8N1 frame on rx, LSB first; stop_ok low sends a bad stop bit
  task automatic send_frame(input byte_t b, input logic stop_ok);
    logic [9:0] bits;
    int         i;
    bits = {stop_ok, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(negedge clk);
      rx = bits[i];
      repeat (CPB - 1) @(negedge clk);
    end
    @(negedge clk);
    rx = 1'b1;
  endtask

  // Decodes tx frames at mid-bit
  initial begin : tx_monitor
    byte_t b;
    int    i;
    forever begin
      @(negedge clk);
      if (rstn === 1'b1 && tx === 1'b0) begin
        repeat (HALF_BIT) @(negedge clk);
        for (i = 0; i < 8; i++) begin
          repeat (CPB) @(negedge clk);
          b[i] = tx;
        end
        repeat (CPB) @(negedge clk);
        if (tx !== 1'b1) abort_run("Stop bit on tx was not high");
        tx_q.push_back(b);
      end
    end
  end

  // Receiver results, one entry per pulse
  initial begin : rx_collector
    err_count = 0;
    forever begin
      @(negedge clk);
      if (rstn === 1'b1) begin
        if (rx_valid === 1'b1) rxv_q.push_back(rx_data);
        if (frame_err === 1'b1) err_count++;
      end
    end
  end

  task automatic wait_tx_frames(input int n);
    int cycles;
    cycles = 0;
    while (tx_q.size() < n) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("Timed out waiting for frames on tx");
    end
  endtask

  task automatic wait_rx_bytes(input int n);
    int cycles;
    cycles = 0;
    while (rxv_q.size() < n) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("Timed out waiting for rx_valid pulses");
    end
  endtask

  function automatic int count_echoes();
    int n;
    n = 0;
    foreach (tx_q[k]) if (tx_q[k] != BURST) n++;
    return n;
  endfunction

  //--------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------

  task automatic idle_after_reset();
    repeat (20 * CPB) begin
      @(negedge clk);
      compare_flag("tx", 1'b1, tx);
      compare_flag("rx_valid", 1'b0, rx_valid);
      compare_flag("frame_err", 1'b0, frame_err);
    end
  endtask

  task automatic receive_and_echo();
    byte_t sent[$];
    byte_t b;
    int    i;
    tx_q.delete();
    rxv_q.delete();
    for (i = 0; i < 8; i++) begin
      b = byte_t'($random(seed));
      sent.push_back(b);
      send_frame(b, 1'b1);
    end
    wait_rx_bytes(8);
    wait_tx_frames(8);
    // Nothing extra may follow
    repeat (2 * FRAME_CYC) @(negedge clk);
    if (rxv_q.size() != 8) abort_run("Wrong number of rx_valid pulses");
    if (tx_q.size() != 8) abort_run("Wrong number of echoed frames on tx");
    for (i = 0; i < 8; i++) begin
      compare_byte("rx_data", sent[i], rxv_q[i]);
      compare_byte("tx echo", sent[i], tx_q[i]);
    end
  endtask

  task automatic burst_alone();
    int n0;
    int i;
    tx_q.delete();
    @(negedge clk);
    dtr = 1'b1;
    wait_tx_frames(4);
    @(negedge clk);
    dtr = 1'b0;
    n0 = tx_q.size();
    repeat (12 * CPB) @(negedge clk);
    if (tx_q.size() > n0 + 1) abort_run("More than one frame after dtr fell");
    repeat (20 * CPB) begin
      @(negedge clk);
      compare_flag("tx", 1'b1, tx);
    end
    for (i = 0; i < tx_q.size(); i++) compare_byte("tx burst", BURST, tx_q[i]);
  endtask

  task automatic burst_with_echo();
    byte_t sent[$];
    byte_t b;
    int    i;
    int    seen;
    int    gap;
    int    cycles;
    tx_q.delete();
    rxv_q.delete();
    @(negedge clk);
    dtr = 1'b1;
    wait_tx_frames(1);
    // Back to back keeps the echo source requesting
    for (i = 0; i < ECHO_BYTES; i++) begin
      b = byte_t'($random(seed));
      if (b == BURST) b = b ^ 8'h80;
      sent.push_back(b);
      send_frame(b, 1'b1);
    end
    wait_rx_bytes(ECHO_BYTES);
    cycles = 0;
    while (count_echoes() < ECHO_BYTES) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("Echoed bytes missing on tx with dtr high");
    end
    @(negedge clk);
    dtr = 1'b0;
    repeat (2 * FRAME_CYC) @(negedge clk);
    for (i = 0; i < ECHO_BYTES; i++) compare_byte("rx_data", sent[i], rxv_q[i]);
    seen = 0;
    gap  = 0;
    for (i = 0; i < tx_q.size(); i++) begin
      if (tx_q[i] == BURST) begin
        gap++;
      end else begin
        if (seen >= ECHO_BYTES) abort_run("Extra echoed frame on tx");
        if (seen > 0 && gap > 1) abort_run("Two burst frames between echoed bytes");
        compare_byte("tx echo", sent[seen], tx_q[i]);
        seen++;
        gap = 0;
      end
    end
  endtask

  task automatic bad_stop_bit();
    byte_t b;
    int    e0;
    int    cycles;
    tx_q.delete();
    rxv_q.delete();
    e0 = err_count;
    b  = byte_t'($random(seed));
    send_frame(b, 1'b0);
    repeat (CPB) @(negedge clk);
    cycles = 0;
    while (err_count == e0) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("No frame_err pulse for a bad stop bit");
    end
    repeat (15 * CPB) @(negedge clk);
    if (err_count != e0 + 1) abort_run("More than one frame_err pulse");
    if (rxv_q.size() != 0) abort_run("rx_valid pulsed for a bad frame");
    if (tx_q.size() != 0) abort_run("Bad frame was echoed on tx");
  endtask

  //--------------------------------------------------------------------
  // Sequence
  //--------------------------------------------------------------------

  initial begin
    seed = 32'h367f_7fbc;
    rstn = 1'b0;
    rx   = 1'b1;
    dtr  = 1'b0;
    repeat (5) @(negedge clk);
    rstn = 1'b1;
    idle_after_reset();
    receive_and_echo();
    burst_alone();
    burst_with_echo();
    bad_stop_bit();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/uart_link.sv
/* Serial console link top, receiver with echo path and burst source
   sharing one transmitter through the arbiter */

`timescale 1ns/1ns
`default_nettype none

module uart_link import uart_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  rx,
  input  logic  dtr,
  output logic  tx,
  output byte_t rx_data,
  output logic  rx_valid,
  output logic  frame_err
);

  // Source side
  logic  q_req;
  byte_t q_data;
  logic  q_ack;
  logic  b_req;
  byte_t b_data;
  logic  b_ack;
  // Transmitter side
  logic  tx_start;
  byte_t tx_byte;
  logic  tx_ready;

  uart_rx i_uart_rx (
    .clk       (clk),
    .rstn      (rstn),
    .rx        (rx),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .frame_err (frame_err)
  );

  // Only good frames are echoed
  echo_queue i_echo_queue (
    .clk       (clk),
    .rstn      (rstn),
    .push      (rx_valid),
    .push_data (rx_data),
    .req       (q_req),
    .data      (q_data),
    .ack       (q_ack)
  );

  burst_source i_burst_source (
    .clk  (clk),
    .rstn (rstn),
    .dtr  (dtr),
    .req  (b_req),
    .data (b_data),
    .ack  (b_ack)
  );

  tx_arbiter i_tx_arbiter (
    .clk        (clk),
    .rstn       (rstn),
    .req_echo   (q_req),
    .req_burst  (b_req),
    .data_echo  (q_data),
    .data_burst (b_data),
    .ack_echo   (q_ack),
    .ack_burst  (b_ack),
    .ready      (tx_ready),
    .start      (tx_start),
    .tx_data    (tx_byte)
  );

  uart_tx i_uart_tx (
    .clk   (clk),
    .rstn  (rstn),
    .start (tx_start),
    .data  (tx_byte),
    .tx    (tx),
    .ready (tx_ready)
  );

endmodule

`default_nettype wire

// File: rtl/tx_arbiter.sv
/* Round-robin arbiter giving the one transmitter to the echo or burst source
   Issues a registered start and ack, then holds off while ready falls */

`timescale 1ns/1ns
`default_nettype none

module tx_arbiter import uart_pkg::*, link_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  req_echo,
  input  logic  req_burst,
  input  byte_t data_echo,
  input  byte_t data_burst,
  output logic  ack_echo,
  output logic  ack_burst,
  input  logic  ready,
  output logic  start,
  output byte_t tx_data
);

  src_t         last_q;
  src_t         winner;
  grant_state_t hold_q;
  logic         grant;

  // Tie goes to the source that did not win last time
  always_comb begin
    if (req_echo && req_burst) begin
      winner = (last_q == SRC_ECHO) ? SRC_BURST : SRC_ECHO;
    end else if (req_burst) begin
      winner = SRC_BURST;
    end else begin
      winner = SRC_ECHO;
    end
  end

  // ready still reads high for two cycles after a start
  assign grant = (req_echo || req_burst) && ready && (hold_q == GNT_OPEN);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      last_q    <= SRC_ECHO;
      hold_q    <= GNT_OPEN;
      start     <= 1'b0;
      ack_echo  <= 1'b0;
      ack_burst <= 1'b0;
    end else begin
      start     <= grant;
      ack_echo  <= grant && (winner == SRC_ECHO);
      ack_burst <= grant && (winner == SRC_BURST);
      if (grant) begin
        last_q <= winner;
        hold_q <= GNT_HOLD_FIRST;
      end else if (hold_q == GNT_HOLD_FIRST) begin
        hold_q <= GNT_HOLD_LAST;
      end else begin
        hold_q <= GNT_OPEN;
      end
    end
  end

  // Byte goes out with the start pulse
  always_ff @(posedge clk) begin
    if (grant) begin
      tx_data <= (winner == SRC_BURST) ? data_burst : data_echo;
    end
  end

endmodule

`default_nettype wire

// File: rtl/burst_source.sv
/* Burst source, offers the fixed character for as long as dtr is high */

`timescale 1ns/1ns
`default_nettype none

`include "uart_cfg.svh"

module burst_source import uart_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  dtr,
  output logic  req,
  output byte_t data,
  input  logic  ack
);

  logic        dtr_s1;
  logic        dtr_s2;

  // dtr comes straight from a pin
  always_ff @(posedge clk) begin
    if (!rstn) begin
      dtr_s1   <= 1'b0;
      dtr_s2   <= 1'b0;
    end else begin
      dtr_s1 <= dtr;
      dtr_s2 <= dtr_s1;
    end
  end

  assign req  = dtr_s2;
  assign data = `UART_BURST_CHAR;

endmodule

`default_nettype wire

// File: rtl/echo_queue.sv
/* Byte FIFO between the receiver and the arbiter for the echo path */

`timescale 1ns/1ns
`default_nettype none

`include "uart_cfg.svh"

module echo_queue import uart_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  push,
  input  byte_t push_data,
  output logic  req,
  output byte_t data,
  input  logic  ack
);

  localparam int DEPTH = `UART_ECHO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  byte_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wraps at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Full queue drops the new byte
  assign do_push = push && (count != CNT_W'(DEPTH));
  assign do_pop  = ack && req;
  assign req     = (count != '0);
  assign data    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
      // Simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
/* UART 8N1 receiver with mid-bit sampling
   Reports each frame half a bit after the stop sample, good or framing error */

`timescale 1ns/1ns
`default_nettype none

`include "uart_cfg.svh"

module uart_rx import uart_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  rx,
  output byte_t rx_data,
  output logic  rx_valid,
  output logic  frame_err
);

  localparam int HALF  = `UART_CLKS_PER_BIT / 2;
  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);

  rx_state_t        state;
  logic             rx_s1;
  logic             rx_s2;
  logic             rx_prev;
  logic             fall;
  logic             tick;
  byte_t            shift_r;
  logic [2:0]       bitc;
  logic             stop_bit;
  // Frame done, waiting to report
  logic             report_pend;
  logic [CNT_W-1:0] report_cnt;

  //--------------------------------------------------------------------
  // Line synchronizer and start edge
  //--------------------------------------------------------------------

  // Idle level after reset so no false edge is seen
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  assign fall = rx_prev && !rx_s2;

  // Half-period first tick lands in the middle of the start bit
  baud_gen i_baud_gen (
    .clk        (clk),
    .rstn       (rstn),
    .ena        (state != RX_IDLE),
    .half_first (1'b1),
    .tick       (tick)
  );

  //--------------------------------------------------------------------
  // Frame FSM
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= RX_IDLE;
      bitc  <= '0;
    end else begin
      case (state)
        RX_IDLE: if (fall) state <= RX_START;
        RX_START: begin
          // Line back high at mid-bit is a glitch
          if (tick) begin
            state <= rx_s2 ? RX_IDLE : RX_DATA;
            bitc  <= '0;
          end
        end
        RX_DATA: begin
          if (tick) begin
            bitc <= bitc + 1'b1;
            if (bitc == 3'd7) state <= RX_STOP;
          end
        end
        RX_STOP: if (tick) state <= RX_IDLE;
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB first, so each bit enters at the top
  always_ff @(posedge clk) begin
    if (state == RX_DATA && tick) begin
      shift_r <= {rx_s2, shift_r[7:1]};
    end
    if (state == RX_STOP && tick) begin
      stop_bit <= rx_s2;
    end
  end

  //--------------------------------------------------------------------
  // Result report
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      report_pend <= 1'b0;
      report_cnt  <= '0;
      rx_valid    <= 1'b0;
      frame_err   <= 1'b0;
    end else begin
      rx_valid  <= 1'b0;
      frame_err <= 1'b0;
      if (state == RX_STOP && tick) begin
        report_pend <= 1'b1;
        report_cnt  <= '0;
      end else if (report_pend) begin
        report_cnt <= report_cnt + 1'b1;
        if (report_cnt == CNT_W'(HALF - 1)) begin
          report_pend <= 1'b0;
          // Low stop bit means a framing error
          rx_valid    <= stop_bit;
          frame_err   <= !stop_bit;
        end
      end
    end
  end

  // Byte held until the next report
  always_ff @(posedge clk) begin
    if (report_pend && report_cnt == CNT_W'(HALF - 1)) begin
      rx_data <= shift_r;
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
/* UART 8N1 transmitter with a registered line that idles high
   Takes a start pulse with its byte and reports ready while idle */

`timescale 1ns/1ns
`default_nettype none

module uart_tx import uart_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  start,
  input  byte_t data,
  output logic  tx,
  output logic  ready
);

  tx_state_t  state;
  logic       start_r;
  byte_t      data_r;
  // Stop bit, eight data bits, start bit; bit 0 is the line
  logic [9:0] shifter;
  logic [3:0] bitc;
  logic       tick;
  logic       load;
  logic       baud_en;

  //--------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      start_r <= 1'b0;
    end else begin
      start_r <= start;
    end
  end

  // Byte captured together with the start request
  always_ff @(posedge clk) begin
    if (start && state == TX_IDLE) begin
      data_r <= data;
    end
  end

  // Ones shift in from the top so the line returns to idle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      shifter <= '1;
    end else if (load) begin
      shifter <= {1'b1, data_r, 1'b0};
    end else if (tick) begin
      shifter <= {1'b1, shifter[9:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bitc <= '0;
    end else if (load) begin
      bitc <= '0;
    end else if (tick) begin
      bitc <= bitc + 1'b1;
    end
  end

  assign tx = shifter[0];

  baud_gen i_baud_gen (
    .clk        (clk),
    .rstn       (rstn),
    .ena        (baud_en),
    .half_first (1'b0),
    .tick       (tick)
  );

  //--------------------------------------------------------------------
  // Controller
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= TX_IDLE;
    end else begin
      case (state)
        TX_IDLE:  if (start_r) state <= TX_START;
        // One cycle to load the frame
        TX_START: state <= TX_TRANS;
        // Tenth tick ends the stop bit
        TX_TRANS: if (tick && bitc == 4'd9) state <= TX_IDLE;
        default:  state <= TX_IDLE;
      endcase
    end
  end

  assign load    = (state == TX_START);
  assign baud_en = (state == TX_TRANS);
  assign ready   = (state == TX_IDLE);

endmodule

`default_nettype wire

// File: rtl/baud_gen.sv
/* Bit period divider, one tick per bit while enabled
   Optionally the first tick comes after half a period for mid-bit sampling */

`timescale 1ns/1ns
`default_nettype none

`include "uart_cfg.svh"

module baud_gen (
  input  logic clk,
  input  logic rstn,
  input  logic ena,
  input  logic half_first,
  output logic tick
);

  localparam int FULL  = `UART_CLKS_PER_BIT;
  localparam int HALF  = `UART_CLKS_PER_BIT / 2;
  localparam int CNT_W = $clog2(FULL);

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] limit;
  // Set until the first tick after enable
  logic             first;

  // Short first period only when asked for
  assign limit = (first && half_first) ? CNT_W'(HALF - 1) : CNT_W'(FULL - 1);
  assign tick  = ena && (cnt == limit);

  // Counter restarts whenever the divider is off
  always_ff @(posedge clk) begin
    if (!rstn || !ena) begin
      cnt   <= '0;
      first <= 1'b1;
    end else if (tick) begin
      cnt   <= '0;
      first <= 1'b0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/link_pkg.sv
/* Transmitter sharing types: source index and the arbiter hold-off state */

`default_nettype none

package link_pkg;

  // Which source owns the next frame
  typedef enum logic {
    SRC_ECHO  = 1'b0,
    SRC_BURST = 1'b1
  } src_t;

  // Cycles left before the arbiter may issue another start
  typedef enum logic [1:0] {
    GNT_OPEN       = 2'd0,
    GNT_HOLD_LAST  = 2'd1,
    GNT_HOLD_FIRST = 2'd2
  } grant_state_t;

endpackage

`default_nettype wire

// File: rtl/uart_pkg.sv
/* Serial side types: payload byte and the transmitter and receiver FSM states */

`default_nettype none

package uart_pkg;

  // One serial payload, LSB goes on the line first
  typedef logic [7:0] byte_t;

  // Transmitter controller
  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,
    TX_START = 2'd1,
    TX_TRANS = 2'd2
  } tx_state_t;

  // Receiver controller
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_t;

endpackage

`default_nettype wire

// File: rtl/uart_cfg.svh
/* UART link build configuration
   Bit timing, echo queue depth and the burst character */

`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Clock cycles per serial bit, at least 4 so that half a bit is 2 or more
`define UART_CLKS_PER_BIT 16

// Number of received bytes the echo path can hold
`define UART_ECHO_DEPTH 4

// Character repeated by the burst source, ASCII "A"
`define UART_BURST_CHAR 8'h41

`endif
